// ==== cpu_execute.f ====
logic/cpu_pkg.sv
logic/cpu_alu.sv
logic/cpu_execute_control.sv
logic/cpu_execute_datapath.sv
logic/cpu_execute_stage.sv
dv/cpu_execute_tb.sv

// ==== dv/cpu_execute_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpu_execute_tb;

  import cpu_pkg::*;

  // stimulus driven into the stage
  logic               clk = 1'b0;
  logic               arst_n;
  logic [DATA_W-1:0]  pc_ex;
  logic [INSTR_W-1:0] ir_ex;
  rf_read_t           rf;
  logic [DATA_W-1:0]  wb_data;
  // stage outputs
  ldst_req_t          ldst;
  alu_out_t           alu;
  wr_stage_t          wr;
  // reference copies of the alu and write-stage registers
  alu_out_t           m_alu;
  wr_stage_t          m_wr;
  integer             seed = 32'hba5c;
  int                 n_errors = 0;
  int                 wait_cnt = 0;

  cpu_execute_stage i_dut (
    .i_clk     (clk),
    .i_arst_n  (arst_n),
    .i_pc_ex   (pc_ex),
    .i_ir_ex   (ir_ex),
    .i_rf      (rf),
    .i_wb_data (wb_data),
    .o_ldst    (ldst),
    .o_alu     (alu),
    .o_wr      (wr)
  );

  // 4 ns period
  always #2 clk = ~clk;

  // reset low for 8 cycles and released off the edge
  initial begin
    arst_n = 1'b0;
    repeat (8) @(posedge clk);
    #1 arst_n = 1'b1;
  end

  // mv, add, sub, ld and mvhi leave a result in Rx
  function automatic logic writes_rx(input logic [INSTR_W-1:0] ir);
    case (ir[3:0])
      4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b0110: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // src reads what the write stage produces
  // call produces R7
  function automatic logic raw_hazard(input logic [2:0] src, input logic [INSTR_W-1:0] ir_w);
    return (writes_rx(ir_w) && src == ir_w[7:5]) || (ir_w[3:0] == 4'b1100 && src == 3'd7);
  endfunction

  // add, sub and cmp
  function automatic logic is_alu(input logic [INSTR_W-1:0] ir);
    return (ir[3:0] >= 4'd1) && (ir[3:0] <= 4'd3);
  endfunction

  // alu ops and ld/st read Rx
  function automatic logic fwd_rx(input logic [INSTR_W-1:0] ir_e, ir_w);
    return (is_alu(ir_e) || ir_e[3:1] == 3'b010) && raw_hazard(ir_e[7:5], ir_w);
  endfunction

  // register forms below 01000 read Ry, nop excluded
  function automatic logic fwd_ry(input logic [INSTR_W-1:0] ir_e, ir_w);
    return (ir_e[4:3] == 2'b00) && (ir_e[2:0] != 3'b111) && raw_hazard(ir_e[10:8], ir_w);
  endfunction

  // biased toward all zeros and all ones so Z shows up
  function automatic logic [DATA_W-1:0] data_word(input logic [31:0] r);
    return (r[1:0] == 2'b00) ? {DATA_W{r[2]}} : r[31:16];
  endfunction

  // mostly R0, R1, R6 and R7 for frequent hazards
  function automatic logic [2:0] reg_field(input logic [3:0] r);
    return r[3] ? {r[1], r[1], r[0]} : r[2:0];
  endfunction

  // one new instruction and operand set
  task automatic drive_inputs();
    logic [31:0] r;
    r        = $random(seed);
    // imm high bits, Ry, Rx, any of the 32 opcodes
    ir_ex    = {r[20:16], reg_field(r[11:8]), reg_field(r[15:12]), r[4:0]};
    pc_ex    = $random(seed);
    rf.datax = data_word($random(seed));
    rf.datay = data_word($random(seed));
    wb_data  = data_word($random(seed));
  endtask

  // model state after one rising edge
  task automatic step_model();
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    logic [DATA_W-1:0] res;
    if (is_alu(ir_ex)) begin
      a = fwd_rx(ir_ex, m_wr.ir) ? wb_data : rf.datax;
      if (fwd_ry(ir_ex, m_wr.ir)) begin
        b = wb_data;
      end else if (ir_ex[4]) begin
        // signed 8-bit immediate
        b = {{8{ir_ex[15]}}, ir_ex[15:8]};
      end else begin
        b = rf.datay;
      end
      res   = ir_ex[1] ? (a - b) : (a + b);
      m_alu = '{r: res, n: res[15], z: (res == '0)};
    end
    // operands follow unless nop sits in write
    if (m_wr.ir[4:0] != 5'b00111) begin
      m_wr.datax = rf.datax;
      m_wr.datay = rf.datay;
    end
    // nop in execute stalls pc and ir
    if (ir_ex[3:0] != 4'b0111) begin
      m_wr.pc = pc_ex;
      m_wr.ir = ir_ex;
    end
  endtask

  // memory request for the inputs now applied
  function automatic ldst_req_t expected_ldst();
    ldst_req_t e;
    logic      mem;
    mem      = (ir_ex[3:1] == 3'b010);
    e.rd     = mem && !ir_ex[0];
    e.wr     = mem && ir_ex[0];
    e.addr   = (mem && fwd_rx(ir_ex, m_wr.ir)) ? wb_data : rf.datax;
    e.wrdata = (mem && fwd_ry(ir_ex, m_wr.ir)) ? wb_data : rf.datay;
    return e;
  endfunction

  task automatic stop_with_failure();
    n_errors++;
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string field, input logic [DATA_W-1:0] got, exp);
    $display("FAILED at %0t ns: %s got %h expected %h", $time, field, got, exp);
    stop_with_failure();
  endtask

  task automatic check_ldst(input ldst_req_t exp);
    if (ldst.rd !== exp.rd)
      report_mismatch("o_ldst.rd", ldst.rd, exp.rd);
    if (ldst.wr !== exp.wr)
      report_mismatch("o_ldst.wr", ldst.wr, exp.wr);
    if (ldst.addr !== exp.addr)
      report_mismatch("o_ldst.addr", ldst.addr, exp.addr);
    if (ldst.wrdata !== exp.wrdata)
      report_mismatch("o_ldst.wrdata", ldst.wrdata, exp.wrdata);
  endtask

  task automatic check_alu(input alu_out_t exp);
    if (alu.r !== exp.r)
      report_mismatch("o_alu.r", alu.r, exp.r);
    if (alu.n !== exp.n)
      report_mismatch("o_alu.n", alu.n, exp.n);
    if (alu.z !== exp.z)
      report_mismatch("o_alu.z", alu.z, exp.z);
  endtask

  task automatic check_wr(input wr_stage_t exp);
    if (wr.pc !== exp.pc)
      report_mismatch("o_wr.pc", wr.pc, exp.pc);
    if (wr.ir !== exp.ir)
      report_mismatch("o_wr.ir", wr.ir, exp.ir);
    if (wr.datax !== exp.datax)
      report_mismatch("o_wr.datax", wr.datax, exp.datax);
    if (wr.datay !== exp.datay)
      report_mismatch("o_wr.datay", wr.datay, exp.datay);
  endtask

  initial begin
    pc_ex   = '0;
    ir_ex   = NOP_INSTR;
    rf      = '0;
    wb_data = '0;
    m_alu   = '0;
    m_wr    = '{pc: '0, ir: NOP_INSTR, datax: '0, datay: '0};
    // bounded wait for reset release
    while (arst_n !== 1'b1) begin
      if (wait_cnt == 20) begin
        $display("reset was not released within 20 cycles");
        stop_with_failure();
      end
      wait_cnt++;
      @(negedge clk);
    end
    // reset state with a nop in execute
    check_alu('0);
    check_wr('{pc: '0, ir: NOP_INSTR, datax: '0, datay: '0});
    check_ldst(expected_ldst());
    repeat (3000) begin
      @(posedge clk);
      step_model();
      // registers settled and new inputs go in 1 ns after the edge
      #1;
      check_alu(m_alu);
      check_wr(m_wr);
      drive_inputs();
      // combinational request sampled mid cycle
      @(negedge clk);
      check_ldst(expected_ldst());
    end
    if (n_errors == 0) begin
      $display("Simulation passed");
      $finish;
    end else begin
      stop_with_failure();
    end
  end

endmodule

`default_nettype wire

// ==== logic/cpu_alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpu_alu (
  input  wire logic                       i_clk,
  input  wire logic                       i_arst_n,
  input  wire logic [cpu_pkg::DATA_W-1:0] i_a,
  input  wire logic [cpu_pkg::DATA_W-1:0] i_b,
  input  wire logic                       i_sub,
  input  wire logic                       i_r_ld,
  input  wire logic                       i_n_ld,
  input  wire logic                       i_z_ld,
  output cpu_pkg::alu_out_t               o_alu
);

  import cpu_pkg::*;

  logic [DATA_W-1:0] result;
  logic [DATA_W-1:0] r_q;
  logic              n_q;
  logic              z_q;

  // a plus b, or a minus b
  assign result = i_sub ? (i_a - i_b) : (i_a + i_b);

  // result register
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      r_q <= '0;
    end else if (i_r_ld) begin
      r_q <= result;
    end
  end

  // negative flag from the sign bit
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      n_q <= 1'b0;
    end else if (i_n_ld) begin
      n_q <= result[DATA_W-1];
    end
  end

  // zero flag
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      z_q <= 1'b0;
    end else if (i_z_ld) begin
      z_q <= (result == '0);
    end
  end

  assign o_alu = '{r: r_q, n: n_q, z: z_q};

endmodule

`default_nettype wire

// ==== logic/cpu_execute_control.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpu_execute_control (
  input  wire logic [cpu_pkg::INSTR_W-1:0] i_ir_ex,
  input  wire logic [cpu_pkg::INSTR_W-1:0] i_ir_wr,
  output cpu_pkg::ex_ctl_t                 o_ctl
);

  import cpu_pkg::*;

  // opcode and register fields of both stages
  logic [OPC_MSB:0] opc_ex;
  logic [OPC_MSB:0] opc_wr;
  logic [2:0]       rx_ex;
  logic [2:0]       ry_ex;
  logic [2:0]       rx_wr;

  // instruction classes
  logic wr_writes_rx;
  logic wr_writes_r7;
  logic ex_is_alu;
  logic ex_uses_rx;
  logic ex_uses_ry;
  logic ex_is_ldst;
  logic ex_is_nop;

  // raw hazard decisions
  logic fw_rx;
  logic fw_ry;

  assign opc_ex = i_ir_ex[OPC_MSB:0];
  assign opc_wr = i_ir_wr[OPC_MSB:0];
  assign rx_ex  = i_ir_ex[RX_MSB:RX_LSB];
  assign ry_ex  = i_ir_ex[RY_MSB:RY_LSB];
  assign rx_wr  = i_ir_wr[RX_MSB:RX_LSB];

  // write stage result lands in Rx
  // mv, add, sub, ld, mvhi
  assign wr_writes_rx = ((opc_wr[3:2] == 2'b00) && (opc_wr[1:0] != 2'b11)) ||
                        ((opc_wr[3:2] == 2'b01) && !opc_wr[0]);

  // call writes the link register
  assign wr_writes_r7 = (opc_wr[3:0] == 4'b1100);

  // add, sub, cmp in either form
  assign ex_is_alu  = (opc_ex[3:2] == 2'b00) && (opc_ex[1:0] != 2'b00);
  // alu operand a and the ld/st address come from Rx
  assign ex_uses_rx = ex_is_alu || ex_is_ldst;

  // register forms up to st read Ry, nop excluded
  assign ex_uses_ry = (opc_ex[4:3] == 2'b00) && (opc_ex[2:0] != 3'b111);

  // ld and st
  assign ex_is_ldst = (opc_ex[3:1] == 3'b010);
  assign ex_is_nop  = (opc_ex[3:0] == OP_NOP_LOW);

  // Rx hazard on a field match or a call into R7
  assign fw_rx = ex_uses_rx &&
                 ((wr_writes_rx && (rx_ex == rx_wr)) ||
                  (wr_writes_r7 && (rx_ex == REG_R7)));

  // Ry hazard against the write Rx field
  assign fw_ry = ex_uses_ry &&
                 ((wr_writes_rx && (ry_ex == rx_wr)) ||
                  (wr_writes_r7 && (ry_ex == REG_R7)));

  always_comb begin
    // pc/ir advance by default and everything else idles
    o_ctl                 = '0;
    o_ctl.pc_wr_ld        = 1'b1;
    o_ctl.ir_wr_ld        = 1'b1;
    o_ctl.alu_a_sel       = ALU_A_RF;
    o_ctl.alu_b_sel       = ALU_B_RF;

    // operands captured unless nop sits in write
    o_ctl.data_wr_ld = (opc_wr != {1'b0, OP_NOP_LOW});

    if (ex_is_alu) begin
      // all three alu registers update together
      o_ctl.alu_r_ld   = 1'b1;
      o_ctl.alu_n_ld   = 1'b1;
      o_ctl.alu_z_ld   = 1'b1;
      // bit 1 set means subtract
      o_ctl.alu_op_sel = opc_ex[1];
      if (fw_rx) begin
        o_ctl.alu_a_sel = ALU_A_FWD;
      end
      if (fw_ry) begin
        o_ctl.alu_b_sel = ALU_B_FWD;
      end else if (opc_ex[OPC_IMM]) begin
        o_ctl.alu_b_sel = ALU_B_IMM;
      end
    end

    if (ex_is_ldst) begin
      // bit 0 tells store from load
      o_ctl.ldst_rd         = !opc_ex[0];
      o_ctl.ldst_wr         = opc_ex[0];
      o_ctl.ldst_addr_sel   = fw_rx;
      o_ctl.ldst_wrdata_sel = fw_ry;
    end

    // nop stalls so the write stage keeps its pc/ir
    if (ex_is_nop) begin
      o_ctl.pc_wr_ld = 1'b0;
      o_ctl.ir_wr_ld = 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== logic/cpu_execute_datapath.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpu_execute_datapath (
  input  wire logic                        i_clk,
  input  wire logic                        i_arst_n,
  input  wire logic [cpu_pkg::DATA_W-1:0]  i_pc_ex,
  input  wire logic [cpu_pkg::INSTR_W-1:0] i_ir_ex,
  input  wire cpu_pkg::rf_read_t           i_rf,
  input  wire logic [cpu_pkg::DATA_W-1:0]  i_wb_data,
  input  wire cpu_pkg::ex_ctl_t            i_ctl,
  output logic [cpu_pkg::INSTR_W-1:0]      o_ir_wr,
  output cpu_pkg::ldst_req_t               o_ldst,
  output cpu_pkg::alu_out_t                o_alu,
  output cpu_pkg::wr_stage_t               o_wr
);

  import cpu_pkg::*;

  // immediate and alu operands
  logic [IMM_W-1:0]  imm;
  logic [DATA_W-1:0] imm_sext;
  logic [DATA_W-1:0] alu_a;
  logic [DATA_W-1:0] alu_b;

  // execute-to-write registers
  logic [DATA_W-1:0]  pc_q;
  logic [INSTR_W-1:0] ir_q;
  logic [DATA_W-1:0]  datax_q;
  logic [DATA_W-1:0]  datay_q;

  // signed 8-bit immediate widened to a word
  assign imm      = i_ir_ex[IMM_MSB:IMM_LSB];
  assign imm_sext = {{(DATA_W-IMM_W){imm[IMM_W-1]}}, imm};

  // operand a, forwarded result or Rx
  assign alu_a = (i_ctl.alu_a_sel == ALU_A_FWD) ? i_wb_data : i_rf.datax;

  // operand b, forwarded result, immediate or Ry
  always_comb begin
    case (i_ctl.alu_b_sel)
      ALU_B_FWD: alu_b = i_wb_data;
      ALU_B_IMM: alu_b = imm_sext;
      ALU_B_RF:  alu_b = i_rf.datay;
      default:   alu_b = i_rf.datay;
    endcase
  end

  cpu_alu u_alu (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_a      (alu_a),
    .i_b      (alu_b),
    .i_sub    (i_ctl.alu_op_sel),
    .i_r_ld   (i_ctl.alu_r_ld),
    .i_n_ld   (i_ctl.alu_n_ld),
    .i_z_ld   (i_ctl.alu_z_ld),
    .o_alu    (o_alu)
  );

  // memory request, same cycle as execute
  always_comb begin
    o_ldst.rd     = i_ctl.ldst_rd;
    o_ldst.wr     = i_ctl.ldst_wr;
    // address from Rx, store data from Ry
    o_ldst.addr   = i_ctl.ldst_addr_sel ? i_wb_data : i_rf.datax;
    o_ldst.wrdata = i_ctl.ldst_wrdata_sel ? i_wb_data : i_rf.datay;
  end

  // pc into write stage, held on nop
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      pc_q <= '0;
    end else if (i_ctl.pc_wr_ld) begin
      pc_q <= i_pc_ex;
    end
  end

  // ir comes out of reset as nop
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      ir_q <= NOP_INSTR;
    end else if (i_ctl.ir_wr_ld) begin
      ir_q <= i_ir_ex;
    end
  end

  // unforwarded operands follow the instruction
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      datax_q <= '0;
      datay_q <= '0;
    end else if (i_ctl.data_wr_ld) begin
      datax_q <= i_rf.datax;
      datay_q <= i_rf.datay;
    end
  end

  // write-stage ir goes back to decode for hazards
  assign o_ir_wr = ir_q;
  assign o_wr    = '{pc: pc_q, ir: ir_q, datax: datax_q, datay: datay_q};

endmodule

`default_nettype wire

// ==== logic/cpu_execute_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpu_execute_stage (
  input  wire logic                        i_clk,
  input  wire logic                        i_arst_n,
  // instruction now in execute
  input  wire logic [cpu_pkg::DATA_W-1:0]  i_pc_ex,
  input  wire logic [cpu_pkg::INSTR_W-1:0] i_ir_ex,
  // register file operands
  input  wire cpu_pkg::rf_read_t           i_rf,
  // result of the instruction in write
  input  wire logic [cpu_pkg::DATA_W-1:0]  i_wb_data,
  output cpu_pkg::ldst_req_t               o_ldst,
  output cpu_pkg::alu_out_t                o_alu,
  output cpu_pkg::wr_stage_t               o_wr
);

  import cpu_pkg::*;

  // decode outputs and write-stage ir loop
  ex_ctl_t            ctl;
  logic [INSTR_W-1:0] ir_wr;

  // decode and hazard detection
  cpu_execute_control u_control (
    .i_ir_ex (i_ir_ex),
    .i_ir_wr (ir_wr),
    .o_ctl   (ctl)
  );

  // operand muxes, alu, pipeline registers
  cpu_execute_datapath u_datapath (
    .i_clk     (i_clk),
    .i_arst_n  (i_arst_n),
    .i_pc_ex   (i_pc_ex),
    .i_ir_ex   (i_ir_ex),
    .i_rf      (i_rf),
    .i_wb_data (i_wb_data),
    .i_ctl     (ctl),
    .o_ir_wr   (ir_wr),
    .o_ldst    (o_ldst),
    .o_alu     (o_alu),
    .o_wr      (o_wr)
  );

endmodule

`default_nettype wire

// ==== logic/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

  // datapath and instruction widths
  localparam int DATA_W  = 16;
  localparam int INSTR_W = 16;

  // instruction field positions
  // opcode sits in 4:0, bit 4 picks the immediate form
  localparam int OPC_MSB = 4;
  localparam int OPC_IMM = 4;
  localparam int RX_MSB  = 7;
  localparam int RX_LSB  = 5;
  localparam int RY_MSB  = 10;
  localparam int RY_LSB  = 8;
  // immediate overlaps Ry, signed 8 bits
  localparam int IMM_MSB = 15;
  localparam int IMM_LSB = 8;
  localparam int IMM_W   = IMM_MSB - IMM_LSB + 1;

  // link register written by call
  localparam logic [2:0] REG_R7 = 3'd7;

  // nop encoding, also write-stage ir after reset
  localparam logic [INSTR_W-1:0] NOP_INSTR  = 16'h0007;
  localparam logic [3:0]         OP_NOP_LOW = 4'b0111;

  // alu operand a sources
  localparam logic [1:0] ALU_A_FWD = 2'd0;
  localparam logic [1:0] ALU_A_RF  = 2'd1;

  // alu operand b sources
  localparam logic [1:0] ALU_B_FWD = 2'd0;
  localparam logic [1:0] ALU_B_IMM = 2'd1;
  localparam logic [1:0] ALU_B_RF  = 2'd2;

  // operands read from the register file
  typedef struct packed {
    logic [DATA_W-1:0] datax;
    logic [DATA_W-1:0] datay;
  } rf_read_t;

  // control bundle from decode to datapath
  typedef struct packed {
    logic       pc_wr_ld;
    logic       ir_wr_ld;
    logic       alu_r_ld;
    logic       alu_n_ld;
    logic       alu_z_ld;
    logic [1:0] alu_a_sel;
    logic [1:0] alu_b_sel;
    logic       alu_op_sel;
    logic       data_wr_ld;
    logic       ldst_rd;
    logic       ldst_wr;
    logic       ldst_addr_sel;
    logic       ldst_wrdata_sel;
  } ex_ctl_t;

  // registered alu result and flags
  typedef struct packed {
    logic [DATA_W-1:0] r;
    logic              n;
    logic              z;
  } alu_out_t;

  // data memory request
  typedef struct packed {
    logic              rd;
    logic              wr;
    logic [DATA_W-1:0] addr;
    logic [DATA_W-1:0] wrdata;
  } ldst_req_t;

  // execute-to-write pipeline registers
  typedef struct packed {
    logic [DATA_W-1:0]  pc;
    logic [INSTR_W-1:0] ir;
    logic [DATA_W-1:0]  datax;
    logic [DATA_W-1:0]  datay;
  } wr_stage_t;

endpackage

`default_nettype wire
